//--- common/nes_board_params.svh
/* NES board glue constants
   widths, counts and core phase values */

`ifndef NES_BOARD_PARAMS_SVH
`define NES_BOARD_PARAMS_SVH

// memory address width
`define NES_ADDR_W 22

// buttons per controller
`define PAD_W 8

// machine reset length after a download, in clock cycles
`define DL_RESET_CYCLES 255

// led divider, top bit toggles at about 1 Hz
`define BLINK_W 24

// core phase counter and the phase owned by PPU memory
`define NES_PHASE_W 2
`define NES_PPU_PHASE 3

`endif

//--- common/nes_board_pkg.sv
/* NES board glue package
   shared types for memory addresses, pad buttons and the arbiter FSM */

`default_nettype none

package nes_board_pkg;

  // byte address into the cartridge and work memory space
  typedef logic [21:0] mem_addr_t;

  // one controller, eight buttons
  typedef logic [7:0] pad_bits_t;

  // memory arbiter FSM
  typedef enum logic [1:0] {
    IDLE,
    LOADER_CYCLE,
    CPU_CYCLE
  } mem_state_e;

  // kind of bus cycle in flight
  typedef enum logic {
    OP_READ,
    OP_WRITE
  } mem_op_e;

endpackage

`default_nettype wire

//--- common/loader_wr_if.sv
/* loader write channel
   one buffered loader write, handed from the holding register to the arbiter */

`timescale 1ns/10ps
`default_nettype none

interface loader_wr_if;

  logic                   pending;
  nes_board_pkg::mem_addr_t addr;
  logic [7:0]             data;
  // pulses in the cycle the bus acks the write
  logic                   taken;

  modport source (
    output pending,
    output addr,
    output data,
    input  taken
  );

  modport sink (
    input  pending,
    input  addr,
    input  data,
    output taken
  );

endinterface

`default_nettype wire

//--- source/reset_sequencer.sv
/* machine reset sequencer
   holds the core in reset at power-on, after downloads and on failures */

`timescale 1ns/10ps
`default_nettype none

`include "nes_board_params.svh"

module reset_sequencer (
  input  wire logic clk,
  input  wire logic reset_nes,
  input  wire logic btn_reset_n_i,
  input  wire logic menu_reset_i,
  input  wire logic downloading_i,
  input  wire logic loader_busy_i,
  input  wire logic loader_fail_i,
  output      logic nes_reset_o
);

  localparam int CNT_W = $clog2(`DL_RESET_CYCLES + 1);

  logic             init_q;
  logic [CNT_W-1:0] dl_cnt_q;

  always_ff @(posedge clk) begin
    if (reset_nes) begin
      init_q      <= 1'b1;
      dl_cnt_q    <= '0;
      nes_reset_o <= 1'b1;
    end else begin
      // first download releases the power-on hold
      if (downloading_i) begin
        init_q <= 1'b0;
      end

      // reload while streaming, count down once the loader is idle
      if (downloading_i) begin
        dl_cnt_q <= CNT_W'(`DL_RESET_CYCLES);
      end else if (!loader_busy_i && dl_cnt_q != '0) begin
        dl_cnt_q <= dl_cnt_q - 1'b1;
      end

      nes_reset_o <= init_q | ~btn_reset_n_i | menu_reset_i |
                     (dl_cnt_q != '0) | loader_fail_i;
    end
  end

endmodule

`default_nettype wire

//--- source/status_led.sv
/* status led
   on while downloading, blinking on loader failure, off otherwise */

`timescale 1ns/10ps
`default_nettype none

`include "nes_board_params.svh"

module status_led (
  input  wire logic clk,
  input  wire logic reset_nes,
  input  wire logic downloading_i,
  input  wire logic loader_fail_i,
  output      logic led_o
);

  // free running, top bit gives roughly 1 Hz
  logic [`BLINK_W-1:0] blink_q;

  always_ff @(posedge clk) begin
    if (reset_nes) begin
      blink_q <= '0;
    end else begin
      blink_q <= blink_q + 1'b1;
    end
  end

  // led is active low
  assign led_o = downloading_i ? 1'b0 :
                 loader_fail_i ? blink_q[`BLINK_W-1] : 1'b1;

endmodule

`default_nettype wire

//--- controller/joypad_serializer.sv
/* joypad serializer
   swaps and reorders the two pads, then shifts them out to the core */

`timescale 1ns/10ps
`default_nettype none

`include "nes_board_params.svh"

module joypad_serializer (
  input  wire logic                     clk,
  input  wire logic                     reset_nes,
  input  wire nes_board_pkg::pad_bits_t pad_a_i,
  input  wire nes_board_pkg::pad_bits_t pad_b_i,
  input  wire logic                     pad_swap_i,
  input  wire logic                     pad_strobe_i,
  input  wire logic [1:0]               pad_clock_i,
  output      logic [1:0]               pad_data_o
);

  // board order to core order
  // low half of the core byte comes from the high half of the board byte, same order,
  // high half comes from the low half, reversed
  function automatic nes_board_pkg::pad_bits_t reorder(input nes_board_pkg::pad_bits_t b);
    nes_board_pkg::pad_bits_t r;
    for (int i = 0; i < `PAD_W / 2; i++) begin
      r[i]              = b[i + `PAD_W / 2];
      r[i + `PAD_W / 2] = b[`PAD_W / 2 - 1 - i];
    end
    return r;
  endfunction

  nes_board_pkg::pad_bits_t core_pad [2];
  nes_board_pkg::pad_bits_t shift_q  [2];
  logic [1:0]               last_clk_q;
  logic [1:0]               clk_fall;

  assign core_pad[0] = reorder(pad_swap_i ? pad_b_i : pad_a_i);
  assign core_pad[1] = reorder(pad_swap_i ? pad_a_i : pad_b_i);

  assign clk_fall = last_clk_q & ~pad_clock_i;

  always_ff @(posedge clk) begin
    if (reset_nes) begin
      shift_q[0] <= '0;
      shift_q[1] <= '0;
      last_clk_q <= '0;
    end else begin
      last_clk_q <= pad_clock_i;
      for (int n = 0; n < 2; n++) begin
        if (pad_strobe_i) begin
          shift_q[n] <= core_pad[n];
        end else if (clk_fall[n]) begin
          shift_q[n] <= {1'b0, shift_q[n][`PAD_W-1:1]};
        end
      end
    end
  end

  assign pad_data_o = {shift_q[1][0], shift_q[0][0]};

endmodule

`default_nettype wire

//--- memory/loader_write_buffer.sv
/* loader write buffer
   holds one loader write until the memory arbiter has posted it */

`timescale 1ns/10ps
`default_nettype none

module loader_write_buffer (
  input  wire logic                     clk,
  input  wire logic                     reset_nes,
  input  wire logic                     loader_wr_i,
  input  wire nes_board_pkg::mem_addr_t loader_addr_i,
  input  wire logic [7:0]               loader_data_i,
  output      logic                     loader_full_o,
  loader_wr_if.source                   wr_o
);

  logic                     pending_q;
  logic                     capture;
  nes_board_pkg::mem_addr_t addr_q;
  logic [7:0]               data_q;

  // a new write is only taken into an empty slot
  assign capture = loader_wr_i & ~pending_q;

  always_ff @(posedge clk) begin
    if (reset_nes) begin
      pending_q <= 1'b0;
    end else if (capture) begin
      pending_q <= 1'b1;
    end else if (wr_o.taken) begin
      pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      addr_q <= loader_addr_i;
      data_q <= loader_data_i;
    end
  end

  assign wr_o.pending  = pending_q;
  assign wr_o.addr     = addr_q;
  assign wr_o.data     = data_q;
  assign loader_full_o = pending_q;

endmodule

`default_nettype wire

//--- memory/mem_arbiter.sv
/* memory arbiter
   wishbone classic master shared by loader writes and cpu accesses */

`timescale 1ns/10ps
`default_nettype none

`include "nes_board_params.svh"

module mem_arbiter (
  input  wire logic                     clk,
  input  wire logic                     reset_nes,
  loader_wr_if.sink                     wr_i,
  input  wire logic [`NES_PHASE_W-1:0]  nes_phase_i,
  input  wire logic                     downloading_i,
  input  wire logic                     loader_busy_i,
  input  wire logic                     cpu_read_i,
  input  wire logic                     cpu_write_i,
  input  wire nes_board_pkg::mem_addr_t cpu_addr_i,
  input  wire logic [7:0]               cpu_wdata_i,
  output      logic [7:0]               cpu_rdata_o,
  output      logic                     cpu_done_o,
  output      logic                     wb_cyc_o,
  output      logic                     wb_stb_o,
  output      logic                     wb_we_o,
  output      logic [`NES_ADDR_W-1:0]   wb_adr_o,
  output      logic [7:0]               wb_dat_o,
  input  wire logic [7:0]               wb_dat_i,
  input  wire logic                     wb_ack_i
);

  nes_board_pkg::mem_state_e state_q;
  nes_board_pkg::mem_op_e    op_q;
  logic                      loading;
  logic                      loader_go;
  logic                      cpu_go;

  // ------------------------------------------------------------------
  // request qualification
  // ------------------------------------------------------------------
  assign loading   = downloading_i | loader_busy_i;
  assign loader_go = wr_i.pending && (nes_phase_i == `NES_PHASE_W'(`NES_PPU_PHASE));

  // cpu still holds its request during the done pulse, so skip that cycle
  assign cpu_go = !wr_i.pending && !loading && (cpu_read_i || cpu_write_i) && !cpu_done_o;

  assign wr_i.taken = (state_q == nes_board_pkg::LOADER_CYCLE) && wb_ack_i;

  // ------------------------------------------------------------------
  // FSM, one bus cycle at a time
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset_nes) begin
      state_q    <= nes_board_pkg::IDLE;
      op_q       <= nes_board_pkg::OP_READ;
      cpu_done_o <= 1'b0;
    end else begin
      cpu_done_o <= 1'b0;
      case (state_q)
        nes_board_pkg::IDLE: begin
          if (loader_go) begin
            state_q <= nes_board_pkg::LOADER_CYCLE;
            op_q    <= nes_board_pkg::OP_WRITE;
          end else if (cpu_go) begin
            state_q <= nes_board_pkg::CPU_CYCLE;
            op_q    <= cpu_write_i ? nes_board_pkg::OP_WRITE : nes_board_pkg::OP_READ;
          end
        end
        nes_board_pkg::LOADER_CYCLE: begin
          if (wb_ack_i) begin
            state_q <= nes_board_pkg::IDLE;
          end
        end
        nes_board_pkg::CPU_CYCLE: begin
          if (wb_ack_i) begin
            state_q    <= nes_board_pkg::IDLE;
            cpu_done_o <= 1'b1;
          end
        end
        default: state_q <= nes_board_pkg::IDLE;
      endcase
    end
  end

  // address and write data, latched when a cycle is launched
  always_ff @(posedge clk) begin
    if (state_q == nes_board_pkg::IDLE) begin
      if (loader_go) begin
        wb_adr_o <= wr_i.addr;
        wb_dat_o <= wr_i.data;
      end else if (cpu_go) begin
        wb_adr_o <= cpu_addr_i;
        wb_dat_o <= cpu_wdata_i;
      end
    end
  end

  // read data held until the next cpu read completes
  always_ff @(posedge clk) begin
    if (state_q == nes_board_pkg::CPU_CYCLE && wb_ack_i && op_q == nes_board_pkg::OP_READ) begin
      cpu_rdata_o <= wb_dat_i;
    end
  end

  assign wb_cyc_o = (state_q != nes_board_pkg::IDLE);
  assign wb_stb_o = wb_cyc_o;
  assign wb_we_o  = (op_q == nes_board_pkg::OP_WRITE);

endmodule

`default_nettype wire

//--- source/nes_board_top.sv
/* NES board glue top
   reset sequencing, status led, joypad serializers and the shared memory port */

`timescale 1ns/10ps
`default_nettype none

`include "nes_board_params.svh"

module nes_board_top (
  input  wire logic                         clk,
  input  wire logic                         reset_nes,
  // machine reset sources
  input  wire logic                         btn_reset_n_i,
  input  wire logic                         menu_reset_i,
  input  wire logic                         downloading_i,
  input  wire logic                         loader_busy_i,
  input  wire logic                         loader_fail_i,
  // loader writes
  input  wire logic                         loader_wr_i,
  input  wire nes_board_pkg::mem_addr_t     loader_addr_i,
  input  wire logic [7:0]                   loader_data_i,
  output      logic                         loader_full_o,
  // controllers
  input  wire nes_board_pkg::pad_bits_t     pad_a_i,
  input  wire nes_board_pkg::pad_bits_t     pad_b_i,
  input  wire logic                         pad_swap_i,
  input  wire logic                         pad_strobe_i,
  input  wire logic [1:0]                   pad_clock_i,
  output      logic [1:0]                   pad_data_o,
  // core cpu side
  input  wire logic [`NES_PHASE_W-1:0]      nes_phase_i,
  input  wire logic                         cpu_read_i,
  input  wire logic                         cpu_write_i,
  input  wire nes_board_pkg::mem_addr_t     cpu_addr_i,
  input  wire logic [7:0]                   cpu_wdata_i,
  output      logic [7:0]                   cpu_rdata_o,
  output      logic                         cpu_done_o,
  // wishbone master
  output      logic                         wb_cyc_o,
  output      logic                         wb_stb_o,
  output      logic                         wb_we_o,
  output      logic [`NES_ADDR_W-1:0]       wb_adr_o,
  output      logic [7:0]                   wb_dat_o,
  input  wire logic [7:0]                   wb_dat_i,
  input  wire logic                         wb_ack_i,
  // board outputs
  output      logic                         nes_reset_o,
  output      logic                         led_o
);

  loader_wr_if u_wr_if ();

  reset_sequencer u_reset_sequencer (
    .clk           (clk),
    .reset_nes     (reset_nes),
    .btn_reset_n_i (btn_reset_n_i),
    .menu_reset_i  (menu_reset_i),
    .downloading_i (downloading_i),
    .loader_busy_i (loader_busy_i),
    .loader_fail_i (loader_fail_i),
    .nes_reset_o   (nes_reset_o)
  );

  status_led u_status_led (
    .clk           (clk),
    .reset_nes     (reset_nes),
    .downloading_i (downloading_i),
    .loader_fail_i (loader_fail_i),
    .led_o         (led_o)
  );

  joypad_serializer u_joypad_serializer (
    .clk          (clk),
    .reset_nes    (reset_nes),
    .pad_a_i      (pad_a_i),
    .pad_b_i      (pad_b_i),
    .pad_swap_i   (pad_swap_i),
    .pad_strobe_i (pad_strobe_i),
    .pad_clock_i  (pad_clock_i),
    .pad_data_o   (pad_data_o)
  );

  loader_write_buffer u_loader_write_buffer (
    .clk           (clk),
    .reset_nes     (reset_nes),
    .loader_wr_i   (loader_wr_i),
    .loader_addr_i (loader_addr_i),
    .loader_data_i (loader_data_i),
    .loader_full_o (loader_full_o),
    .wr_o          (u_wr_if.source)
  );

  mem_arbiter u_mem_arbiter (
    .clk           (clk),
    .reset_nes     (reset_nes),
    .wr_i          (u_wr_if.sink),
    .nes_phase_i   (nes_phase_i),
    .downloading_i (downloading_i),
    .loader_busy_i (loader_busy_i),
    .cpu_read_i    (cpu_read_i),
    .cpu_write_i   (cpu_write_i),
    .cpu_addr_i    (cpu_addr_i),
    .cpu_wdata_i   (cpu_wdata_i),
    .cpu_rdata_o   (cpu_rdata_o),
    .cpu_done_o    (cpu_done_o),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_we_o       (wb_we_o),
    .wb_adr_o      (wb_adr_o),
    .wb_dat_o      (wb_dat_o),
    .wb_dat_i      (wb_dat_i),
    .wb_ack_i      (wb_ack_i)
  );

endmodule

`default_nettype wire

//--- test/nes_board_properties.sv
/* NES board bus and loader properties
   concurrent checks on the wishbone port and the loader write handshake */

`timescale 1ns/10ps
`default_nettype none

`include "nes_board_params.svh"

module nes_board_properties (
  input wire logic                      clk,
  input wire logic                      reset_nes,
  input wire logic                      wb_cyc_o,
  input wire logic                      wb_stb_o,
  input wire logic                      wb_we_o,
  input wire logic [`NES_ADDR_W-1:0]    wb_adr_o,
  input wire logic [7:0]                wb_dat_o,
  input wire logic                      wb_ack_i,
  input wire logic                      loader_full_o,
  input wire logic                      loader_wr_i,
  input wire logic [`NES_PHASE_W-1:0]   nes_phase_i
);

  // failed assertion count
  int unsigned violations = 0;

  // cycle held with stable address, data and direction until the slave acks
  bus_stable: assert property (@(posedge clk) disable iff (reset_nes)
    (wb_cyc_o && !wb_ack_i) |=>
      (wb_cyc_o && $stable(wb_adr_o) && $stable(wb_dat_o) && $stable(wb_we_o)))
    else begin
      violations++;
      $error("wishbone cycle changed address, data or we before ack");
    end

  cyc_has_stb: assert property (@(posedge clk) disable iff (reset_nes)
    wb_cyc_o |-> wb_stb_o)
    else begin
      violations++;
      $error("wb_cyc_o high without wb_stb_o");
    end

  // idle with a pending loader write outside the PPU phase, nothing may start
  loader_in_ppu_phase: assert property (@(posedge clk) disable iff (reset_nes)
    (!wb_cyc_o && loader_full_o && nes_phase_i != `NES_PHASE_W'(`NES_PPU_PHASE)) |=> !wb_cyc_o)
    else begin
      violations++;
      $error("bus cycle started outside the PPU phase with a loader write pending");
    end

  no_write_when_full: assert property (@(posedge clk) disable iff (reset_nes)
    loader_full_o |-> !loader_wr_i)
    else begin
      violations++;
      $error("loader_wr_i pulsed while loader_full_o was high");
    end

endmodule

bind nes_board_top nes_board_properties u_props (
  .clk           (clk),
  .reset_nes     (reset_nes),
  .wb_cyc_o      (wb_cyc_o),
  .wb_stb_o      (wb_stb_o),
  .wb_we_o       (wb_we_o),
  .wb_adr_o      (wb_adr_o),
  .wb_dat_o      (wb_dat_o),
  .wb_ack_i      (wb_ack_i),
  .loader_full_o (loader_full_o),
  .loader_wr_i   (loader_wr_i),
  .nes_phase_i   (nes_phase_i)
);

`default_nettype wire

//--- test/tb_nes_board.sv
/* NES board glue testbench
   drives reset, pads, loader and cpu traffic against a wishbone memory model */

`timescale 1ns/10ps
`default_nettype none

`include "nes_board_params.svh"

module tb_nes_board;

  localparam int SEED            = 26;
  localparam int CLK_PERIOD      = 10;
  // 200 us budget, the download reset is the longest sequence
  localparam int WATCHDOG_CYCLES = 20000;
  localparam int WAIT_LIMIT      = 200;
  localparam int N_LOADER        = 4;

  logic                               clk;
  logic                               reset_nes;
  logic                               btn_reset_n_i;
  logic                               menu_reset_i;
  logic                               downloading_i;
  logic                               loader_busy_i;
  logic                               loader_fail_i;
  logic                               loader_wr_i;
  nes_board_pkg::mem_addr_t           loader_addr_i;
  logic [7:0]                         loader_data_i;
  logic                               loader_full_o;
  nes_board_pkg::pad_bits_t           pad_a_i;
  nes_board_pkg::pad_bits_t           pad_b_i;
  logic                               pad_swap_i;
  logic                               pad_strobe_i;
  logic [1:0]                         pad_clock_i;
  logic [1:0]                         pad_data_o;
  logic [`NES_PHASE_W-1:0]            nes_phase_i = '0;
  logic                               cpu_read_i;
  logic                               cpu_write_i;
  nes_board_pkg::mem_addr_t           cpu_addr_i;
  logic [7:0]                         cpu_wdata_i;
  logic [7:0]                         cpu_rdata_o;
  logic                               cpu_done_o;
  logic                               wb_cyc_o;
  logic                               wb_stb_o;
  logic                               wb_we_o;
  logic [`NES_ADDR_W-1:0]             wb_adr_o;
  logic [7:0]                         wb_dat_o;
  logic [7:0]                         wb_dat_i = '0;
  logic                               wb_ack_i = 1'b0;
  logic                               nes_reset_o;
  logic                               led_o;

  logic [7:0]                         mem [nes_board_pkg::mem_addr_t];
  logic                               in_cycle = 1'b0;
  int                                 ack_wait;
  logic [31:0]                        ack_rng = SEED;
  logic [31:0]                        stim_rng = SEED;
  logic [`BLINK_W-1:0]                div_model;
  int                                 errors = 0;
  int                                 high_cycles;
  nes_board_pkg::mem_addr_t           lw_addr [N_LOADER];
  logic [7:0]                         lw_data [N_LOADER];

  nes_board_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout, watchdog stopped the run after %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] r;
    r = x ^ (x << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
  endfunction

  // core bits 0..3 from board bits 4..7, core bits 4..7 from board bits 3..0
  function automatic nes_board_pkg::pad_bits_t core_order(input nes_board_pkg::pad_bits_t b);
    return {b[0], b[1], b[2], b[3], b[7], b[6], b[5], b[4]};
  endfunction

  task automatic tick();
    @(negedge clk);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      errors++;
      $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  // ------------------------------------------------------------------
  // wishbone memory model with random ack delay, plus phase counter
  // ------------------------------------------------------------------
  always @(negedge clk) begin
    nes_phase_i <= nes_phase_i + 1'b1;
    if (reset_nes || wb_ack_i) begin
      wb_ack_i <= 1'b0;
      in_cycle = 1'b0;
    end else if (wb_cyc_o && wb_stb_o) begin
      if (!in_cycle) begin
        in_cycle = 1'b1;
        ack_rng  = xorshift32(ack_rng);
        ack_wait = int'(ack_rng[1:0]);
        // write without a cpu write request is a loader write, decided in this phase
        if (wb_we_o && !cpu_write_i) begin
          check_value("loader phase", `NES_PPU_PHASE, nes_phase_i);
        end
      end
      if (ack_wait == 0) begin
        wb_ack_i <= 1'b1;
        if (wb_we_o) begin
          mem[wb_adr_o] = wb_dat_o;
        end else begin
          wb_dat_i <= mem[wb_adr_o];
        end
      end else begin
        ack_wait--;
      end
    end
  end

  // reference for the led divider
  always @(posedge clk) begin
    if (reset_nes) begin
      div_model <= '0;
    end else begin
      div_model <= div_model + 1'b1;
    end
  end

  task automatic cpu_access(input string name, input logic write,
                            input nes_board_pkg::mem_addr_t addr, input logic [7:0] wdata);
    int waited;
    waited      = 0;
    cpu_addr_i  = addr;
    cpu_wdata_i = wdata;
    cpu_write_i = write;
    cpu_read_i  = !write;
    tick();
    while (!cpu_done_o && waited < WAIT_LIMIT) begin
      waited++;
      tick();
    end
    if (!cpu_done_o) begin
      errors++;
      $display("%s: no cpu_done_o pulse within %0d cycles", name, WAIT_LIMIT);
    end
    cpu_write_i = 1'b0;
    cpu_read_i  = 1'b0;
  endtask

  task automatic loader_write(input nes_board_pkg::mem_addr_t addr, input logic [7:0] data);
    int waited;
    waited = 0;
    while (loader_full_o && waited < WAIT_LIMIT) begin
      waited++;
      tick();
    end
    if (loader_full_o) begin
      errors++;
      $display("loader buffer stayed full, write to %0h dropped", addr);
    end else begin
      loader_addr_i = addr;
      loader_data_i = data;
      loader_wr_i   = 1'b1;
      tick();
      loader_wr_i   = 1'b0;
      tick();
    end
  endtask

  task automatic wait_bus_idle();
    int waited;
    waited = 0;
    while ((loader_full_o || wb_cyc_o) && waited < WAIT_LIMIT) begin
      waited++;
      tick();
    end
    if (loader_full_o || wb_cyc_o) begin
      errors++;
      $display("memory port did not go idle within %0d cycles", WAIT_LIMIT);
    end
  endtask

  task automatic shift_pads(input string name, input logic swap);
    nes_board_pkg::pad_bits_t exp_a;
    nes_board_pkg::pad_bits_t exp_b;
    stim_rng     = xorshift32(stim_rng);
    pad_a_i      = stim_rng[7:0];
    pad_b_i      = stim_rng[15:8];
    pad_swap_i   = swap;
    exp_a        = core_order(swap ? stim_rng[15:8] : stim_rng[7:0]);
    exp_b        = core_order(swap ? stim_rng[7:0] : stim_rng[15:8]);
    pad_strobe_i = 1'b1;
    tick();
    pad_strobe_i = 1'b0;
    // eight buttons, then zero fill
    for (int k = 0; k < `PAD_W + 2; k++) begin
      check_value(name, {exp_b[0], exp_a[0]}, pad_data_o);
      pad_clock_i = 2'b11;
      tick();
      pad_clock_i = 2'b00;
      tick();
      exp_a = exp_a >> 1;
      exp_b = exp_b >> 1;
    end
  endtask

  initial begin
    reset_nes     = 1'b1;
    btn_reset_n_i = 1'b1;
    menu_reset_i  = 1'b0;
    downloading_i = 1'b0;
    loader_busy_i = 1'b0;
    loader_fail_i = 1'b0;
    loader_wr_i   = 1'b0;
    loader_addr_i = '0;
    loader_data_i = '0;
    pad_a_i       = '0;
    pad_b_i       = '0;
    pad_swap_i    = 1'b0;
    pad_strobe_i  = 1'b0;
    pad_clock_i   = 2'b00;
    cpu_read_i    = 1'b0;
    cpu_write_i   = 1'b0;
    cpu_addr_i    = '0;
    cpu_wdata_i   = '0;
    repeat (10) tick();
    reset_nes = 1'b0;

    // power-on hold until the first download
    repeat (20) begin
      tick();
      check_value("reset hold", 1, nes_reset_o);
      check_value("led idle", 1, led_o);
    end

    // download running, cpu kept off the bus
    downloading_i = 1'b1;
    loader_busy_i = 1'b1;
    cpu_write_i   = 1'b1;
    cpu_addr_i    = 22'h200010;
    cpu_wdata_i   = 8'h5a;
    repeat (20) begin
      tick();
      check_value("cpu blocked", 0, wb_cyc_o);
      check_value("cpu blocked done", 0, cpu_done_o);
      check_value("led download", 0, led_o);
    end
    cpu_write_i = 1'b0;

    for (int i = 0; i < N_LOADER; i++) begin
      stim_rng   = xorshift32(stim_rng);
      lw_addr[i] = {1'b0, stim_rng[20:0]};
      lw_data[i] = stim_rng[31:24];
      loader_write(lw_addr[i], lw_data[i]);
    end
    wait_bus_idle();
    for (int i = 0; i < N_LOADER; i++) begin
      check_value("loader write", lw_data[i], mem[lw_addr[i]]);
    end

    // ------------------------------------------------------------------
    // post-download reset, counted from the first idle cycle
    // ------------------------------------------------------------------
    downloading_i = 1'b0;
    loader_busy_i = 1'b0;
    high_cycles   = 0;
    tick();
    while (nes_reset_o && high_cycles < 4 * `DL_RESET_CYCLES) begin
      high_cycles++;
      tick();
    end
    check_value("download reset", `DL_RESET_CYCLES, high_cycles);
    check_value("led after download", 1, led_o);

    btn_reset_n_i = 1'b0;
    tick();
    check_value("button reset", 1, nes_reset_o);
    btn_reset_n_i = 1'b1;
    tick();
    check_value("button release", 0, nes_reset_o);
    menu_reset_i = 1'b1;
    tick();
    check_value("menu reset", 1, nes_reset_o);
    menu_reset_i = 1'b0;
    tick();
    check_value("menu release", 0, nes_reset_o);

    shift_pads("joypad straight", 1'b0);
    shift_pads("joypad swapped", 1'b1);

    // cpu write then read back, plus one loader byte
    for (int i = 0; i < 3; i++) begin
      stim_rng = xorshift32(stim_rng);
      cpu_access("cpu write", 1'b1, {1'b1, stim_rng[20:0]}, stim_rng[31:24]);
      cpu_access("cpu read", 1'b0, {1'b1, stim_rng[20:0]}, 8'h00);
      check_value("cpu read", stim_rng[31:24], cpu_rdata_o);
    end
    cpu_access("cpu read loader", 1'b0, lw_addr[0], 8'h00);
    check_value("cpu read loader", lw_data[0], cpu_rdata_o);

    loader_fail_i = 1'b1;
    repeat (8) begin
      tick();
      check_value("led blink", div_model[`BLINK_W-1], led_o);
      check_value("fail reset", 1, nes_reset_o);
    end
    loader_fail_i = 1'b0;
    tick();
    check_value("led idle", 1, led_o);
    repeat (4) tick();

    $display("closing report: %0d check errors, %0d assertion failures",
             errors, u_dut.u_props.violations);
    if (errors == 0 && u_dut.u_props.violations == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- nes_board_top.f
+incdir+common
common/nes_board_pkg.sv
common/loader_wr_if.sv
source/reset_sequencer.sv
source/status_led.sv
controller/joypad_serializer.sv
memory/loader_write_buffer.sv
memory/mem_arbiter.sv
source/nes_board_top.sv
test/nes_board_properties.sv
test/tb_nes_board.sv

//--- Bender.yml
package:
  name: nes_board

sources:
  - include_dirs:
      - common
    files:
      - common/nes_board_pkg.sv
      - common/loader_wr_if.sv
      - source/reset_sequencer.sv
      - source/status_led.sv
      - controller/joypad_serializer.sv
      - memory/loader_write_buffer.sv
      - memory/mem_arbiter.sv
      - source/nes_board_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/nes_board_properties.sv
      - test/tb_nes_board.sv
